//--- Makefile
VERILATOR ?= verilator
TOP       ?= uart_tx_bank_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	@out="$$(./$(BUILD_DIR)/$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- hw/done_collector.sv
`timescale 1ns/100ps
`include "uart_config.svh"

module done_collector (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`UART_LANES-1:0]  done_flag,
    output logic [`UART_LANES-1:0]  done_clear,
    output logic                    done_req,
    output uart_pkg::lane_id_t      done_lane,
    input  logic                    done_ack
);

    import uart_pkg::*;

    typedef enum logic [1:0] {
        C_SCAN,
        C_REQ,
        C_REL
    } coll_state_t;

    coll_state_t state;
    lane_id_t next_lane;
    logic found;

    // search starts one past the lane served last, wrapping at the top.
    always_comb begin
        found = 1'b0;
        next_lane = done_lane;
        for (int i = 1; i <= `UART_LANES; i++) begin
            if (!found && done_flag[(int'(done_lane) + i) % `UART_LANES]) begin
                found = 1'b1;
                next_lane = lane_id_t'((int'(done_lane) + i) % `UART_LANES);
            end
        end
    end

    // done_lane doubles as the round-robin pointer, so lane 0 is first after reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= C_SCAN;
            done_req   <= 1'b0;
            done_lane  <= lane_id_t'(`UART_LANES - 1);
            done_clear <= '0;
        end else begin
            done_clear <= '0;
            case (state)
                C_SCAN: begin
                    if (found) begin
                        done_lane <= next_lane;
                        done_req  <= 1'b1;
                        state     <= C_REQ;
                    end
                end
                C_REQ: begin
                    if (done_ack) begin
                        done_req   <= 1'b0;
                        done_clear <= lane_onehot(done_lane);
                        state      <= C_REL;
                    end
                end
                C_REL: begin
                    // wait for the host to finish its side before the next request.
                    if (!done_ack) begin
                        state <= C_SCAN;
                    end
                end
                default: begin
                    state <= C_SCAN;
                end
            endcase
        end
    end

endmodule

//--- hw/tx_dispatch.sv
`timescale 1ns/100ps
`include "uart_config.svh"

module tx_dispatch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tx_req,
    input  uart_pkg::lane_id_t      tx_lane,
    input  logic [7:0]              tx_data,
    output logic                    tx_ack,
    input  logic [`UART_LANES-1:0]  lane_busy,
    output logic [`UART_LANES-1:0]  load,
    output logic [7:0]              load_data
);

    import uart_pkg::*;

    typedef enum logic [1:0] {
        S_WAIT_REQ,
        S_ACK_HIGH,
        S_WAIT_REL
    } disp_state_t;

    disp_state_t state;
    logic [`UART_LANES-1:0] sel;
    logic lane_free;

    assign sel = lane_onehot(tx_lane);

    // the addressed lane must be idle before its byte is handed over.
    assign lane_free = ~|(sel & lane_busy);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= S_WAIT_REQ;
            tx_ack <= 1'b0;
            load   <= '0;
        end else begin
            load <= '0;
            case (state)
                S_WAIT_REQ: begin
                    // a busy lane stalls the host here with tx_ack held low.
                    if (tx_req && lane_free) begin
                        load  <= sel;
                        state <= S_ACK_HIGH;
                    end
                end
                S_ACK_HIGH: begin
                    // the load pulse is out now, so the byte is taken.
                    tx_ack <= 1'b1;
                    state  <= S_WAIT_REL;
                end
                S_WAIT_REL: begin
                    if (!tx_req) begin
                        tx_ack <= 1'b0;
                        state  <= S_WAIT_REQ;
                    end
                end
                default: begin
                    state <= S_WAIT_REQ;
                end
            endcase
        end
    end

    // the byte is captured together with the load decision.
    always_ff @(posedge clk) begin
        if (state == S_WAIT_REQ && tx_req && lane_free) begin
            load_data <= tx_data;
        end
    end

endmodule

//--- hw/uart_pkg.sv
`include "uart_config.svh"

package uart_pkg;

    // index of one transmit lane.
    typedef logic [$clog2(`UART_LANES)-1:0] lane_id_t;

    // life cycle of a single transmitter lane.
    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_SEND,
        LANE_DONE
    } lane_state_t;

    // one-hot select for a lane, shared by the dispatcher and the collector.
    function automatic logic [`UART_LANES-1:0] lane_onehot(lane_id_t id);
        lane_onehot = '0;
        lane_onehot[id] = 1'b1;
    endfunction

endpackage

//--- hw/uart_tx_bank.sv
`timescale 1ns/100ps
`include "uart_config.svh"

module uart_tx_bank (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tx_req,
    input  uart_pkg::lane_id_t      tx_lane,
    input  logic [7:0]              tx_data,
    output logic                    tx_ack,
    output logic                    done_req,
    output uart_pkg::lane_id_t      done_lane,
    input  logic                    done_ack,
    output logic [`UART_LANES-1:0]  tx_line
);

    import uart_pkg::*;

    logic [`UART_LANES-1:0] load;
    logic [`UART_LANES-1:0] lane_busy;
    logic [`UART_LANES-1:0] done_flag;
    logic [`UART_LANES-1:0] done_clear;
    logic [7:0] load_data;

    tx_dispatch tx_dispatch_i (
        .clk       (clk),
        .rst       (rst),
        .tx_req    (tx_req),
        .tx_lane   (tx_lane),
        .tx_data   (tx_data),
        .tx_ack    (tx_ack),
        .lane_busy (lane_busy),
        .load      (load),
        .load_data (load_data)
    );

    // every lane sees the shared byte, and only its own load bit selects it.
    for (genvar i = 0; i < `UART_LANES; i++) begin : g_lane
        uart_tx_lane uart_tx_lane_i (
            .clk        (clk),
            .rst        (rst),
            .load       (load[i]),
            .load_data  (load_data),
            .done_clear (done_clear[i]),
            .busy       (lane_busy[i]),
            .done_flag  (done_flag[i]),
            .line       (tx_line[i])
        );
    end

    done_collector done_collector_i (
        .clk        (clk),
        .rst        (rst),
        .done_flag  (done_flag),
        .done_clear (done_clear),
        .done_req   (done_req),
        .done_lane  (done_lane),
        .done_ack   (done_ack)
    );

endmodule

//--- hw/uart_tx_lane.sv
`timescale 1ns/100ps
`include "uart_config.svh"

module uart_tx_lane (
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic [7:0] load_data,
    input  logic       done_clear,
    output logic       busy,
    output logic       done_flag,
    output logic       line
);

    import uart_pkg::*;

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam int BIT_W = $clog2(`UART_FRAME_BITS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`UART_FRAME_BITS - 1);

    lane_state_t state;
    logic [`UART_FRAME_BITS-1:0] shift_reg;
    logic [CNT_W-1:0] clk_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic bit_end;

    assign bit_end = (clk_cnt == CNT_LAST);

    // the serial line is simply the low end of the frame register.
    assign line = shift_reg[0];

    assign busy = (state != LANE_IDLE);
    assign done_flag = (state == LANE_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= LANE_IDLE;
            shift_reg <= '1;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (load) begin
                        // stop bit, data LSB first, start bit at the bottom.
                        shift_reg <= {1'b1, load_data, 1'b0};
                        clk_cnt   <= '0;
                        bit_cnt   <= '0;
                        state     <= LANE_SEND;
                    end
                end
                LANE_SEND: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        if (bit_cnt == BIT_LAST) begin
                            shift_reg <= '1;
                            state     <= LANE_DONE;
                        end else begin
                            shift_reg <= {1'b1, shift_reg[`UART_FRAME_BITS-1:1]};
                            bit_cnt   <= bit_cnt + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                LANE_DONE: begin
                    // the lane stays busy until its completion is drained.
                    if (done_clear) begin
                        state <= LANE_IDLE;
                    end
                end
                default: begin
                    state <= LANE_IDLE;
                end
            endcase
        end
    end

endmodule

//--- include/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// number of independent transmit lanes, two or more.
`define UART_LANES 4

// clock cycles per serial bit.
// 868 gives 115200 baud at 100 MHz; 16 keeps simulation short.
`define UART_CLKS_PER_BIT 16

// start bit, eight data bits and one stop bit.
`define UART_FRAME_BITS 10

`endif

//--- sim.f
+incdir+include
hw/uart_pkg.sv
hw/tx_dispatch.sv
hw/uart_tx_lane.sv
hw/done_collector.sv
hw/uart_tx_bank.sv
sim/tb_clock.sv
sim/uart_tx_bank_checker.sv
sim/uart_tx_bank_tb.sv

//--- sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 100 ns period.
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // reset is released just after the eighth rising edge, like any other input.
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
    end

endmodule

//--- sim/uart_tx_bank_checker.sv
`timescale 1ns/100ps
`include "uart_config.svh"

module uart_tx_bank_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   tx_req,
    input logic                   tx_ack,
    input logic                   done_req,
    input uart_pkg::lane_id_t     done_lane,
    input logic                   done_ack,
    input logic [`UART_LANES-1:0] lane_busy,
    input logic [`UART_LANES-1:0] done_flag,
    input logic [`UART_LANES-1:0] tx_line
);

    import uart_pkg::*;

    int fail_count = 0;
    lane_state_t lane_state [`UART_LANES];

    // a lane is busy from load until it is cleared, and flags done only at the end.
    always_comb begin
        for (int i = 0; i < `UART_LANES; i++) begin
            if (!lane_busy[i]) begin
                lane_state[i] = LANE_IDLE;
            end else if (done_flag[i]) begin
                lane_state[i] = LANE_DONE;
            end else begin
                lane_state[i] = LANE_SEND;
            end
        end
    end

    req_held: assert property (@(posedge clk) disable iff (rst)
        $fell(tx_req) |-> tx_ack)
        else begin
            fail_count++;
            $error("tx_req fell before tx_ack rose");
        end

    ack_held: assert property (@(posedge clk) disable iff (rst)
        $fell(tx_ack) |-> !$past(tx_req))
        else begin
            fail_count++;
            $error("tx_ack fell while tx_req was high");
        end

    // the collector may not withdraw or change a completion before the host answers.
    done_held: assert property (@(posedge clk) disable iff (rst)
        done_req && !done_ack |=> done_req && $stable(done_lane))
        else begin
            fail_count++;
            $error("done_req or done_lane changed before done_ack");
        end

    for (genvar i = 0; i < `UART_LANES; i++) begin : g_idle
        idle_high: assert property (@(posedge clk) disable iff (rst)
            lane_state[i] == LANE_IDLE |-> tx_line[i])
            else begin
                fail_count++;
                $error("line of lane %0d is low while the lane is idle", i);
            end
    end

endmodule

//--- sim/uart_tx_bank_tb.sv
`timescale 1ns/100ps
`include "uart_config.svh"

module uart_tx_bank_tb;

    import uart_pkg::*;

    localparam int LANES = `UART_LANES;
    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int FRAME_BITS = `UART_FRAME_BITS;
    localparam int HALF = CPB / 2;
    localparam int FRAME_TIMEOUT = 2 * FRAME_BITS * CPB * LANES;
    localparam int WAIT_TIMEOUT = 2 * CPB + 50;
    localparam int HOLD_CYCLES = 3 * CPB;

    logic clk;
    logic rst;
    logic tx_req;
    lane_id_t tx_lane;
    logic [7:0] tx_data;
    logic tx_ack;
    logic done_req;
    lane_id_t done_lane;
    logic done_ack;
    logic [LANES-1:0] tx_line;

    int errors = 0;
    int rx_errors = 0;
    integer seed;
    int frames_sent [LANES];
    logic [7:0] sent_data [LANES];

    logic rx_active [LANES];
    int rx_phase [LANES];
    logic [FRAME_BITS-1:0] rx_frame [LANES];
    logic [7:0] rx_data [LANES];
    int rx_count [LANES];

    tb_clock tb_clock_i (
        .clk (clk),
        .rst (rst)
    );

    uart_tx_bank uart_tx_bank_i (
        .clk       (clk),
        .rst       (rst),
        .tx_req    (tx_req),
        .tx_lane   (tx_lane),
        .tx_data   (tx_data),
        .tx_ack    (tx_ack),
        .done_req  (done_req),
        .done_lane (done_lane),
        .done_ack  (done_ack),
        .tx_line   (tx_line)
    );

    bind uart_tx_bank uart_tx_bank_checker uart_tx_bank_checker_i (
        .clk       (clk),
        .rst       (rst),
        .tx_req    (tx_req),
        .tx_ack    (tx_ack),
        .done_req  (done_req),
        .done_lane (done_lane),
        .done_ack  (done_ack),
        .lane_busy (lane_busy),
        .done_flag (done_flag),
        .tx_line   (tx_line)
    );

    // each lane's decoder counts phase 0 at the first low sample and reads bits mid-period.
    always @(negedge clk) begin : decode
        int bit_idx;
        for (int i = 0; i < LANES; i++) begin
            if (rst) begin
                rx_active[i] = 1'b0;
                rx_count[i] = 0;
            end else if (!rx_active[i]) begin
                if (tx_line[i] == 1'b0) begin
                    rx_active[i] = 1'b1;
                    rx_phase[i] = 0;
                end
            end else begin
                rx_phase[i]++;
                if (rx_phase[i] >= HALF - 1 && (rx_phase[i] - (HALF - 1)) % CPB == 0) begin
                    bit_idx = (rx_phase[i] - (HALF - 1)) / CPB;
                    rx_frame[i][bit_idx] = tx_line[i];
                    if (bit_idx == FRAME_BITS - 1) begin
                        assert (rx_frame[i][0] == 1'b0) else begin
                            rx_errors++;
                            $display("FAIL start_bit lane %0d: expected 0, actual %0b",
                                     i, rx_frame[i][0]);
                        end
                        assert (rx_frame[i][FRAME_BITS-1] == 1'b1) else begin
                            rx_errors++;
                            $display("FAIL stop_bit lane %0d: expected 1, actual %0b",
                                     i, rx_frame[i][FRAME_BITS-1]);
                        end
                        rx_data[i] = rx_frame[i][8:1];
                        rx_count[i]++;
                        rx_active[i] = 1'b0;
                    end
                end
            end
        end
    end

    initial begin
        repeat (40 * FRAME_BITS * CPB * LANES) @(posedge clk);
        $display("simulation did not finish within its cycle limit");
        $display("Test failed");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            errors++;
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic wait_tx_ack(input logic level);
        int t;
        t = 0;
        while (tx_ack !== level && t < WAIT_TIMEOUT) begin
            step();
            t++;
        end
        if (tx_ack !== level) begin
            errors++;
            $display("tx_ack did not go to %0b within %0d cycles", level, WAIT_TIMEOUT);
        end
    endtask

    task automatic wait_done_req(input logic level);
        int t;
        t = 0;
        while (done_req !== level && t < WAIT_TIMEOUT) begin
            step();
            t++;
        end
        if (done_req !== level) begin
            errors++;
            $display("done_req did not go to %0b within %0d cycles", level, WAIT_TIMEOUT);
        end
    endtask

    task automatic request_byte(input lane_id_t lane, input logic [7:0] data);
        step();
        tx_lane = lane;
        tx_data = data;
        tx_req = 1'b1;
        frames_sent[lane]++;
        sent_data[lane] = data;
    endtask

    task automatic finish_request();
        wait_tx_ack(1'b1);
        tx_req = 1'b0;
        wait_tx_ack(1'b0);
    endtask

    task automatic send_byte(input lane_id_t lane, input logic [7:0] data);
        request_byte(lane, data);
        finish_request();
    endtask

    task automatic wait_frame(input string name, input int lane);
        int t;
        t = 0;
        while (rx_count[lane] < frames_sent[lane] && t < FRAME_TIMEOUT) begin
            step();
            t++;
        end
        if (rx_count[lane] < frames_sent[lane]) begin
            errors++;
            $display("no frame decoded on lane %0d within %0d cycles", lane, FRAME_TIMEOUT);
        end
        check_value($sformatf("%s_data_lane%0d", name, lane), sent_data[lane], rx_data[lane]);
    endtask

    task automatic check_frame_counts(input string name);
        for (int i = 0; i < LANES; i++) begin
            check_value($sformatf("%s_frames_lane%0d", name, i), frames_sent[i], rx_count[i]);
        end
    endtask

    task automatic drain_done(output lane_id_t lane);
        wait_done_req(1'b1);
        lane = done_lane;
        done_ack = 1'b1;
        wait_done_req(1'b0);
        done_ack = 1'b0;
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            step();
            check_value(name, 0, done_req);
        end
    endtask

    initial begin : main
        lane_id_t lane;
        lane_id_t got;
        int start;
        int t;
        logic [LANES-1:0] seen;

        seed = 32'h5873;
        tx_req = 1'b0;
        tx_lane = '0;
        tx_data = '0;
        done_ack = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            frames_sent[i] = 0;
            sent_data[i] = '0;
        end

        t = 0;
        while (rst !== 1'b0 && t < 20) begin
            step();
            t++;
        end
        if (rst !== 1'b0) begin
            errors++;
            $display("reset was never released");
        end
        step();

        check_value("reset_lines", (1 << LANES) - 1, tx_line);
        check_value("reset_tx_ack", 0, tx_ack);
        check_value("reset_done_req", 0, done_req);

        for (int i = 0; i < LANES; i++) begin
            lane = lane_id_t'(i);
            send_byte(lane, 8'($random(seed)));
            wait_frame("lane_walk", i);
            check_frame_counts("lane_walk");
            drain_done(got);
            check_value("lane_walk_done_lane", i, got);
            expect_quiet("lane_walk_extra_done", 4);
        end

        // the completion is left pending so the second byte has to stall.
        lane = lane_id_t'($unsigned($random(seed)) % LANES);
        send_byte(lane, 8'($random(seed)));
        wait_frame("backpressure_first", lane);
        wait_done_req(1'b1);
        request_byte(lane, 8'($random(seed)));
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            step();
            check_value("backpressure_ack", 0, tx_ack);
        end
        drain_done(got);
        check_value("backpressure_done_lane", lane, got);
        finish_request();
        wait_frame("backpressure_second", lane);
        check_frame_counts("backpressure");
        drain_done(got);
        check_value("backpressure_second_done_lane", lane, got);

        start = $unsigned($random(seed)) % LANES;
        for (int i = 0; i < LANES; i++) begin
            send_byte(lane_id_t'((start + i) % LANES), 8'($random(seed)));
        end
        for (int i = 0; i < LANES; i++) begin
            wait_frame("overlap", i);
        end
        check_frame_counts("overlap");
        seen = '0;
        for (int i = 0; i < LANES; i++) begin
            drain_done(got);
            check_value("overlap_repeat_lane", 0, seen[got]);
            seen[got] = 1'b1;
        end
        check_value("overlap_done_set", (1 << LANES) - 1, seen);
        expect_quiet("overlap_extra_done", 4);

        step();
        $display("errors: checks %0d, frames %0d, assertions %0d", errors, rx_errors,
                 uart_tx_bank_i.uart_tx_bank_checker_i.fail_count);
        if (errors == 0 && rx_errors == 0 &&
            uart_tx_bank_i.uart_tx_bank_checker_i.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
